// ==== common/fleet_pkg.sv ====
// Shared constants, cell codes and stream payloads of the naval battle core
// Imported by every module that handles coordinates, commands or peer messages
`default_nettype none

package fleet_pkg;

    localparam int BOARD_DIM  = 10;
    localparam int CELL_COUNT = 100;
    localparam int MAX_SHIPS  = 10;

    // Row * BOARD_DIM + col
    typedef logic [6:0] cell_idx_t;

    typedef struct packed {
        logic [3:0] row;
        logic [3:0] col;
    } cell_pos_t;

    typedef enum logic [1:0] {
        EMPTY = 2'b00,
        SHIP  = 2'b01,
        HIT   = 2'b10,
        MISS  = 2'b11
    } cell_code_t;

    typedef enum logic {
        SHOT   = 1'b0,
        ANSWER = 1'b1
    } peer_op_t;

    // code only carries meaning for ANSWER
    typedef struct packed {
        peer_op_t   op;
        cell_pos_t  pos;
        cell_code_t code;
    } peer_msg_t;

    typedef enum logic [1:0] {
        CLICK       = 2'd0,
        PEER_SHOT   = 2'd1,
        PEER_ANSWER = 2'd2
    } cmd_op_t;

    typedef struct packed {
        cmd_op_t    op;
        cell_idx_t  idx;
        cell_code_t code;
    } board_cmd_t;

    typedef enum logic [1:0] {
        SHOT_OUT    = 2'd0,
        ANSWER_OUT  = 2'd1,
        SHOT_RESULT = 2'd2
    } evt_kind_t;

    // fresh marks the first answer or result that touches a cell
    typedef struct packed {
        evt_kind_t  kind;
        cell_idx_t  idx;
        cell_code_t code;
        logic       fresh;
    } board_evt_t;

    function automatic logic pos_in_range(cell_pos_t pos);
        return (pos.row < BOARD_DIM) && (pos.col < BOARD_DIM);
    endfunction

    function automatic cell_idx_t pos_to_idx(cell_pos_t pos);
        return cell_idx_t'(pos.row * BOARD_DIM + pos.col);
    endfunction

    function automatic cell_pos_t idx_to_pos(cell_idx_t idx);
        cell_pos_t pos;
        pos.row = 4'(idx / BOARD_DIM);
        pos.col = 4'(idx % BOARD_DIM);
        return pos;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/stream_fifo.sv ====
// Small valid/ready FIFO for any packed payload type
// Buffers mouse clicks and both directions of the peer link
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    output logic          in_ready,
    input  payload_t      in_data,
    output logic          out_valid,
    input  wire logic     out_ready,
    output payload_t      out_data
);

    payload_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       push;
    logic                       pop;

    assign in_ready  = (count != ($clog2(DEPTH+1))'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keep the level
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // A full buffer has its write pointer back on the oldest entry
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        (count == ($clog2(DEPTH+1))'(DEPTH)) |-> (wr_ptr == rd_ptr)
    );

endmodule

`default_nettype wire

// ==== verilog/move_decoder.sv ====
// Merges clicks and peer messages into one board command stream
// Drops out-of-range coordinates and counts them; the peer side has priority
`default_nettype none

module move_decoder import fleet_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  click_valid,
    output logic       click_ready,
    input  cell_pos_t  click_pos,
    input  wire logic  peer_valid,
    output logic       peer_ready,
    input  peer_msg_t  peer_msg,
    output logic       cmd_valid,
    input  wire logic  cmd_ready,
    output board_cmd_t cmd,
    output logic [7:0] bad_count
);

    logic       slot_free;
    logic       take_peer;
    logic       take_click;
    logic       take;
    cell_pos_t  sel_pos;
    logic       sel_ok;
    board_cmd_t next_cmd;

    // The slot takes a new entry when empty or draining this cycle
    assign slot_free = !cmd_valid || cmd_ready;

    assign peer_ready  = slot_free;
    assign click_ready = slot_free && !peer_valid;

    assign take_peer  = peer_valid && peer_ready;
    assign take_click = click_valid && click_ready;
    assign take       = take_peer || take_click;

    assign sel_pos = take_peer ? peer_msg.pos : click_pos;
    assign sel_ok  = pos_in_range(sel_pos);

    always_comb begin
        next_cmd.idx = pos_to_idx(sel_pos);
        if (take_peer) begin
            next_cmd.op   = (peer_msg.op == ANSWER) ? PEER_ANSWER : PEER_SHOT;
            next_cmd.code = peer_msg.code;
        end else begin
            next_cmd.op   = CLICK;
            next_cmd.code = EMPTY;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_valid <= 1'b0;
            bad_count <= '0;
        end else begin
            if (take) begin
                // A rejected coordinate is consumed but leaves the slot empty
                cmd_valid <= sel_ok;
            end else if (cmd_ready) begin
                cmd_valid <= 1'b0;
            end
            if (take && !sel_ok && bad_count != 8'hff) begin
                bad_count <= bad_count + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && sel_ok) begin
            cmd <= next_cmd;
        end
    end

endmodule

`default_nettype wire

// ==== game_board/game_board.sv ====
// Host and guest boards with fleet placement, turn keeping and shot resolution
// Also serves the two registered cell reads used by the video side
`default_nettype none

module game_board import fleet_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  cmd_valid,
    output logic       cmd_ready,
    input  board_cmd_t cmd,
    output logic       evt_valid,
    input  wire logic  evt_ready,
    output board_evt_t evt,
    input  wire logic  game_over,
    input  wire logic  host_starts,
    input  cell_idx_t  ship_xy_host,
    input  cell_idx_t  ship_xy_guest,
    output cell_code_t ship_code_host,
    output cell_code_t ship_code_guest,
    output logic [3:0] ships_placed,
    output logic       fleet_ready,
    output logic       your_turn
);

    cell_code_t board_host  [CELL_COUNT];
    cell_code_t board_guest [CELL_COUNT];

    logic       cmd_fire;
    logic       live;
    cell_code_t host_cell;
    cell_code_t guest_cell;
    logic       evt_emit;
    board_evt_t evt_next;

    // A held event stalls the command side
    assign cmd_ready   = !evt_valid || evt_ready;
    assign cmd_fire    = cmd_valid && cmd_ready;
    assign live        = cmd_fire && !game_over;
    assign fleet_ready = (ships_placed == 4'(MAX_SHIPS));

    assign host_cell  = board_host[cmd.idx];
    assign guest_cell = board_guest[cmd.idx];

    always_comb begin
        evt_emit = 1'b0;
        evt_next = '{kind: SHOT_RESULT, idx: cmd.idx, code: guest_cell, fresh: 1'b0};
        if (live) begin
            case (cmd.op)
                CLICK: begin
                    if (fleet_ready && your_turn && guest_cell == EMPTY) begin
                        evt_emit      = 1'b1;
                        evt_next.kind = SHOT_OUT;
                        evt_next.code = EMPTY;
                    end
                end
                PEER_SHOT: begin
                    evt_emit       = 1'b1;
                    evt_next.kind  = ANSWER_OUT;
                    evt_next.fresh = (host_cell == EMPTY) || (host_cell == SHIP);
                    case (host_cell)
                        SHIP:    evt_next.code = HIT;
                        EMPTY:   evt_next.code = MISS;
                        default: evt_next.code = host_cell;
                    endcase
                end
                PEER_ANSWER: begin
                    evt_emit       = 1'b1;
                    evt_next.fresh = (guest_cell == EMPTY);
                    if (guest_cell == EMPTY) begin
                        evt_next.code = cmd.code;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            board_host   <= '{default: EMPTY};
            board_guest  <= '{default: EMPTY};
            ships_placed <= '0;
            your_turn    <= 1'b0;
            evt_valid    <= 1'b0;
        end else begin
            if (evt_emit) begin
                evt_valid <= 1'b1;
            end else if (evt_ready) begin
                evt_valid <= 1'b0;
            end
            // Placement phase: clicks only drop ships on the host board
            if (live && cmd.op == CLICK && !fleet_ready && host_cell == EMPTY) begin
                board_host[cmd.idx] <= SHIP;
                ships_placed        <= ships_placed + 4'd1;
                if (ships_placed == 4'(MAX_SHIPS - 1)) begin
                    your_turn <= host_starts;
                end
            end
            if (evt_emit && evt_next.kind == SHOT_OUT) begin
                your_turn <= 1'b0;
            end
            if (evt_emit && evt_next.kind == ANSWER_OUT) begin
                your_turn <= 1'b1;
                if (evt_next.fresh) begin
                    board_host[cmd.idx] <= evt_next.code;
                end
            end
            if (evt_emit && evt_next.kind == SHOT_RESULT && evt_next.fresh) begin
                board_guest[cmd.idx] <= cmd.code;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (evt_emit) begin
            evt <= evt_next;
        end
        ship_code_host  <= (ship_xy_host < CELL_COUNT) ? board_host[ship_xy_host] : EMPTY;
        ship_code_guest <= (ship_xy_guest < CELL_COUNT) ? board_guest[ship_xy_guest] : EMPTY;
    end

    a_fleet_limit: assert property (
        @(posedge clk) disable iff (rst)
        ships_placed <= 4'(MAX_SHIPS)
    );

    a_evt_hold: assert property (
        @(posedge clk) disable iff (rst)
        (evt_valid && !evt_ready) |=> (evt_valid && $stable(evt))
    );

endmodule

`default_nettype wire

// ==== verilog/shot_reporter.sv ====
// Turns board events into outgoing peer messages and keeps the hit score
// Declares the end of the game when either side has sunk every ship cell
`default_nettype none

module shot_reporter import fleet_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  evt_valid,
    output logic       evt_ready,
    input  board_evt_t evt,
    output logic       tx_valid,
    input  wire logic  tx_ready,
    output peer_msg_t  tx_msg,
    output logic [3:0] hits_taken,
    output logic [3:0] hits_scored,
    output logic       game_over,
    output logic       won
);

    logic is_result;
    logic evt_fire;
    logic take_hit;
    logic score_hit;

    // Results stay local, everything else goes out on the link
    assign is_result = (evt.kind == SHOT_RESULT);
    assign evt_ready = is_result || tx_ready;
    assign tx_valid  = evt_valid && !is_result;
    assign evt_fire  = evt_valid && evt_ready;

    always_comb begin
        tx_msg.pos = idx_to_pos(evt.idx);
        if (evt.kind == SHOT_OUT) begin
            tx_msg.op   = SHOT;
            tx_msg.code = EMPTY;
        end else begin
            tx_msg.op   = ANSWER;
            tx_msg.code = evt.code;
        end
    end

    assign take_hit  = evt_fire && evt.kind == ANSWER_OUT && evt.fresh && evt.code == HIT;
    assign score_hit = evt_fire && is_result && evt.fresh && evt.code == HIT;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hits_taken  <= '0;
            hits_scored <= '0;
            game_over   <= 1'b0;
            won         <= 1'b0;
        end else if (!game_over) begin
            if (take_hit) begin
                hits_taken <= hits_taken + 4'd1;
                if (hits_taken == 4'(MAX_SHIPS - 1)) begin
                    game_over <= 1'b1;
                end
            end
            if (score_hit) begin
                hits_scored <= hits_scored + 4'd1;
                if (hits_scored == 4'(MAX_SHIPS - 1)) begin
                    game_over <= 1'b1;
                    won       <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fleet_game_top.sv ====
// Game-state core of the naval battle: input FIFOs, decoder, board and reporter
// Clicks come in as grid positions, the peer link as shot and answer messages
`default_nettype none

module fleet_game_top import fleet_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  host_starts,
    input  wire logic  click_valid,
    output logic       click_ready,
    input  cell_pos_t  click_pos,
    input  wire logic  peer_rx_valid,
    output logic       peer_rx_ready,
    input  peer_msg_t  peer_rx,
    output logic       peer_tx_valid,
    input  wire logic  peer_tx_ready,
    output peer_msg_t  peer_tx,
    input  cell_idx_t  ship_xy_host,
    input  cell_idx_t  ship_xy_guest,
    output cell_code_t ship_code_host,
    output cell_code_t ship_code_guest,
    output logic [3:0] ships_placed,
    output logic       fleet_ready,
    output logic       your_turn,
    output logic [3:0] hits_taken,
    output logic [3:0] hits_scored,
    output logic       game_over,
    output logic       won,
    output logic [7:0] bad_count
);

    logic       clk_q_valid;
    logic       clk_q_ready;
    cell_pos_t  clk_q_pos;
    logic       rx_q_valid;
    logic       rx_q_ready;
    peer_msg_t  rx_q_msg;
    logic       cmd_valid;
    logic       cmd_ready;
    board_cmd_t cmd;
    logic       evt_valid;
    logic       evt_ready;
    board_evt_t evt;
    logic       tx_valid;
    logic       tx_ready;
    peer_msg_t  tx_msg;

    stream_fifo #(.payload_t(cell_pos_t)) click_fifo (
        .clk, .rst,
        .in_valid (click_valid), .in_ready (click_ready), .in_data (click_pos),
        .out_valid(clk_q_valid), .out_ready(clk_q_ready), .out_data(clk_q_pos)
    );

    stream_fifo #(.payload_t(peer_msg_t)) rx_fifo (
        .clk, .rst,
        .in_valid (peer_rx_valid), .in_ready (peer_rx_ready), .in_data (peer_rx),
        .out_valid(rx_q_valid),    .out_ready(rx_q_ready),    .out_data(rx_q_msg)
    );

    move_decoder move_decoder_inst (
        .clk, .rst,
        .click_valid(clk_q_valid), .click_ready(clk_q_ready), .click_pos(clk_q_pos),
        .peer_valid (rx_q_valid),  .peer_ready (rx_q_ready),  .peer_msg (rx_q_msg),
        .cmd_valid, .cmd_ready, .cmd, .bad_count
    );

    game_board game_board_inst (
        .clk, .rst,
        .cmd_valid, .cmd_ready, .cmd,
        .evt_valid, .evt_ready, .evt,
        .game_over, .host_starts,
        .ship_xy_host, .ship_xy_guest, .ship_code_host, .ship_code_guest,
        .ships_placed, .fleet_ready, .your_turn
    );

    shot_reporter shot_reporter_inst (
        .clk, .rst,
        .evt_valid, .evt_ready, .evt,
        .tx_valid, .tx_ready, .tx_msg,
        .hits_taken, .hits_scored, .game_over, .won
    );

    stream_fifo #(.payload_t(peer_msg_t)) tx_fifo (
        .clk, .rst,
        .in_valid (tx_valid),      .in_ready (tx_ready),      .in_data (tx_msg),
        .out_valid(peer_tx_valid), .out_ready(peer_tx_ready), .out_data(peer_tx)
    );

endmodule

`default_nettype wire

// ==== verif/fleet_game_tb.sv ====
// Testbench for the naval battle core: placement, peer shots, firing, back-pressure, game end
// Keeps reference boards and predicts every peer_tx message, counter and display read
`default_nettype none

module fleet_game_tb import fleet_pkg::*; ();

    // About ten times the planned traffic
    localparam int TIMEOUT_CYCLES = 20000;
    // Deepest path without a message: click FIFO, decoder slot, board
    localparam int PIPE_CYCLES    = 12;

    logic       clk;
    logic       rst;
    logic       host_starts;
    logic       click_valid;
    logic       click_ready;
    cell_pos_t  click_pos;
    logic       peer_rx_valid;
    logic       peer_rx_ready;
    peer_msg_t  peer_rx;
    logic       peer_tx_valid;
    logic       peer_tx_ready;
    peer_msg_t  peer_tx;
    cell_idx_t  ship_xy_host;
    cell_idx_t  ship_xy_guest;
    cell_code_t ship_code_host;
    cell_code_t ship_code_guest;
    logic [3:0] ships_placed;
    logic       fleet_ready;
    logic       your_turn;
    logic [3:0] hits_taken;
    logic [3:0] hits_scored;
    logic       game_over;
    logic       won;
    logic [7:0] bad_count;

    cell_code_t ref_host  [CELL_COUNT];
    cell_code_t ref_guest [CELL_COUNT];
    int         ref_ships;
    int         ref_taken;
    int         ref_scored;
    int         ref_bad;
    bit         ref_turn;
    bit         ref_over;
    bit         ref_won;

    peer_msg_t  exp_q [$];
    peer_msg_t  exp_msg;
    peer_msg_t  seen_msg;
    logic       seen_valid;
    logic       seen_ready;
    bit         random_ready;
    int         value_errs;
    int         flow_errs;
    int         cycle_count;

    fleet_game_top fleet_game_top_inst (
        .clk, .rst, .host_starts,
        .click_valid, .click_ready, .click_pos,
        .peer_rx_valid, .peer_rx_ready, .peer_rx,
        .peer_tx_valid, .peer_tx_ready, .peer_tx,
        .ship_xy_host, .ship_xy_guest, .ship_code_host, .ship_code_guest,
        .ships_placed, .fleet_ready, .your_turn,
        .hits_taken, .hits_scored, .game_over, .won, .bad_count
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic cell_pos_t make_pos(input int row, input int col);
        cell_pos_t p;
        p.row = 4'(row);
        p.col = 4'(col);
        return p;
    endfunction

    // Random cell on one board that holds the given code, -1 if none
    function automatic int find_cell(input bit guest, input cell_code_t code);
        int start;
        int idx;
        start = $urandom % CELL_COUNT;
        for (int k = 0; k < CELL_COUNT; k++) begin
            idx = (start + k) % CELL_COUNT;
            if ((guest ? ref_guest[idx] : ref_host[idx]) == code) begin
                return idx;
            end
        end
        return -1;
    endfunction

    // Reference model: applies one command to the reference boards
    // Returns 1 when the move must leave on peer_tx as msg
    function automatic bit predict_move(input cmd_op_t op, input cell_pos_t pos,
                                        input cell_code_t code, output peer_msg_t msg);
        int idx;
        bit emit;
        emit     = 1'b0;
        msg.op   = ANSWER;
        msg.pos  = pos;
        msg.code = EMPTY;
        if (pos.row >= BOARD_DIM || pos.col >= BOARD_DIM) begin
            if (ref_bad < 255) begin
                ref_bad++;
            end
            return 1'b0;
        end
        if (ref_over) begin
            return 1'b0;
        end
        idx = pos.row * BOARD_DIM + pos.col;
        case (op)
            CLICK: begin
                if (ref_ships < MAX_SHIPS) begin
                    if (ref_host[idx] == EMPTY) begin
                        ref_host[idx] = SHIP;
                        ref_ships++;
                        if (ref_ships == MAX_SHIPS) begin
                            ref_turn = host_starts;
                        end
                    end
                end else if (ref_turn && ref_guest[idx] == EMPTY) begin
                    emit     = 1'b1;
                    msg.op   = SHOT;
                    ref_turn = 1'b0;
                end
            end
            PEER_SHOT: begin
                emit     = 1'b1;
                ref_turn = 1'b1;
                if (ref_host[idx] == SHIP) begin
                    msg.code      = HIT;
                    ref_host[idx] = HIT;
                    ref_taken++;
                end else if (ref_host[idx] == EMPTY) begin
                    msg.code      = MISS;
                    ref_host[idx] = MISS;
                end else begin
                    msg.code = ref_host[idx];
                end
            end
            default: begin
                if (ref_guest[idx] == EMPTY) begin
                    ref_guest[idx] = code;
                    if (code == HIT) begin
                        ref_scored++;
                    end
                end
            end
        endcase
        if (ref_taken == MAX_SHIPS) begin
            ref_over = 1'b1;
        end
        if (ref_scored == MAX_SHIPS) begin
            ref_over = 1'b1;
            ref_won  = 1'b1;
        end
        return emit;
    endfunction

    task automatic send_click(input cell_pos_t pos);
        peer_msg_t msg;
        if (predict_move(CLICK, pos, EMPTY, msg)) begin
            exp_q.push_back(msg);
        end
        click_pos   = pos;
        click_valid = 1'b1;
        while (!click_ready) @(negedge clk);
        @(negedge clk);
        click_valid = 1'b0;
    endtask

    task automatic send_peer(input peer_op_t op, input cell_pos_t pos, input cell_code_t code);
        peer_msg_t msg;
        cmd_op_t   cop;
        cop = (op == ANSWER) ? PEER_ANSWER : PEER_SHOT;
        if (predict_move(cop, pos, code, msg)) begin
            exp_q.push_back(msg);
        end
        peer_rx.op    = op;
        peer_rx.pos   = pos;
        peer_rx.code  = code;
        peer_rx_valid = 1'b1;
        while (!peer_rx_ready) @(negedge clk);
        @(negedge clk);
        peer_rx_valid = 1'b0;
    endtask

    // Waits for all expected messages, lets the pipeline empty, then checks the status outputs
    task automatic settle_and_check();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (PIPE_CYCLES) @(negedge clk);
        check("ships_placed", ships_placed, ref_ships);
        check("fleet_ready", fleet_ready, ref_ships == MAX_SHIPS);
        check("your_turn", your_turn, ref_turn);
        check("hits_taken", hits_taken, ref_taken);
        check("hits_scored", hits_scored, ref_scored);
        check("game_over", game_over, ref_over);
        check("won", won, ref_won);
        check("bad_count", bad_count, ref_bad);
    endtask

    task automatic sweep_boards();
        for (int i = 0; i < CELL_COUNT; i++) begin
            ship_xy_host  = cell_idx_t'(i);
            ship_xy_guest = cell_idx_t'(i);
            @(negedge clk);
            check($sformatf("host cell %0d", i), ship_code_host, ref_host[i]);
            check($sformatf("guest cell %0d", i), ship_code_guest, ref_guest[i]);
        end
    endtask

    // A transfer seen at one falling edge happened on the rising edge before the next
    always @(negedge clk) begin
        if (seen_valid && seen_ready) begin
            if (exp_q.size() == 0) begin
                flow_errs++;
                $display("Unexpected peer message %h at time %0t", seen_msg, $time);
            end else begin
                exp_msg = exp_q.pop_front();
                check("peer_tx", seen_msg, exp_msg);
            end
        end
        if (random_ready) begin
            peer_tx_ready = ($urandom % 4) != 0;
        end else begin
            peer_tx_ready = 1'b1;
        end
        seen_valid = peer_tx_valid;
        seen_ready = peer_tx_ready;
        seen_msg   = peer_tx;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles with %0d messages outstanding",
                 cycle_count, exp_q.size());
        $display("Verification failed");
        $finish;
    end

    initial begin
        int        seed_val;
        int        idx;
        cell_pos_t first;
        cell_pos_t pos1;
        cell_pos_t pos2;
        seed_val      = $urandom(32'hb038a93a);
        rst           = 1'b1;
        host_starts   = 1'b0;
        click_valid   = 1'b0;
        click_pos     = '0;
        peer_rx_valid = 1'b0;
        peer_rx       = '0;
        peer_tx_ready = 1'b1;
        ship_xy_host  = '0;
        ship_xy_guest = '0;
        seen_valid    = 1'b0;
        seen_ready    = 1'b0;
        seen_msg      = '0;
        random_ready  = 1'b0;
        value_errs    = 0;
        flow_errs     = 0;
        ref_ships     = 0;
        ref_taken     = 0;
        ref_scored    = 0;
        ref_bad       = 0;
        ref_turn      = 1'b0;
        ref_over      = 1'b0;
        ref_won       = 1'b0;
        foreach (ref_host[i]) begin
            ref_host[i]  = EMPTY;
            ref_guest[i] = EMPTY;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check("peer_tx_valid after reset", peer_tx_valid, 1'b0);
        settle_and_check();

        // Placement with a duplicate, then an eleventh click
        first = make_pos($urandom % BOARD_DIM, $urandom % BOARD_DIM);
        send_click(first);
        send_click(first);
        while (ref_ships < MAX_SHIPS) begin
            send_click(make_pos($urandom % BOARD_DIM, $urandom % BOARD_DIM));
        end
        idx = find_cell(1'b0, EMPTY);
        send_click(make_pos(idx / BOARD_DIM, idx % BOARD_DIM));
        settle_and_check();
        sweep_boards();

        // Out-of-range clicks and peer messages
        send_click(make_pos(10, 0));
        send_click(make_pos(3, 12));
        send_click(make_pos(15, 15));
        send_peer(SHOT, make_pos(11, 2), EMPTY);
        send_peer(ANSWER, make_pos(4, 10), HIT);
        send_peer(SHOT, make_pos(12, 12), EMPTY);
        settle_and_check();
        sweep_boards();

        // Answering peer shots, with repeats of the first one
        first = make_pos($urandom % BOARD_DIM, $urandom % BOARD_DIM);
        send_peer(SHOT, first, EMPTY);
        for (int n = 0; n < 12; n++) begin
            send_peer(SHOT, make_pos($urandom % BOARD_DIM, $urandom % BOARD_DIM), EMPTY);
        end
        send_peer(SHOT, first, EMPTY);
        send_peer(SHOT, first, EMPTY);
        settle_and_check();

        // Firing on our turn, out of turn and at known cells
        idx  = find_cell(1'b1, EMPTY);
        pos1 = make_pos(idx / BOARD_DIM, idx % BOARD_DIM);
        send_click(pos1);
        settle_and_check();
        idx = find_cell(1'b1, EMPTY);
        send_click(make_pos(idx / BOARD_DIM, idx % BOARD_DIM));
        settle_and_check();
        send_peer(ANSWER, pos1, HIT);
        settle_and_check();
        send_peer(SHOT, make_pos($urandom % BOARD_DIM, $urandom % BOARD_DIM), EMPTY);
        settle_and_check();
        send_click(pos1);
        settle_and_check();
        idx  = find_cell(1'b1, EMPTY);
        pos2 = make_pos(idx / BOARD_DIM, idx % BOARD_DIM);
        send_click(pos2);
        settle_and_check();
        send_peer(ANSWER, pos2, MISS);
        settle_and_check();
        send_peer(ANSWER, pos2, HIT);
        settle_and_check();
        sweep_boards();

        // Long peer traffic away from ships under random back-pressure
        random_ready = 1'b1;
        for (int n = 0; n < 150; n++) begin
            do begin
                idx = $urandom % CELL_COUNT;
            end while (ref_host[idx] == SHIP);
            send_peer(SHOT, make_pos(idx / BOARD_DIM, idx % BOARD_DIM), EMPTY);
        end
        settle_and_check();

        // Sink every remaining ship, then nothing may change
        for (int i = 0; i < CELL_COUNT; i++) begin
            if (ref_host[i] == SHIP) begin
                send_peer(SHOT, make_pos(i / BOARD_DIM, i % BOARD_DIM), EMPTY);
            end
        end
        settle_and_check();
        check("game_over at end", game_over, 1'b1);
        check("won at end", won, 1'b0);
        for (int n = 0; n < 3; n++) begin
            idx = find_cell(1'b1, EMPTY);
            send_click(make_pos(idx / BOARD_DIM, idx % BOARD_DIM));
            send_peer(SHOT, make_pos($urandom % BOARD_DIM, $urandom % BOARD_DIM), EMPTY);
            send_peer(ANSWER, make_pos(idx / BOARD_DIM, idx % BOARD_DIM), HIT);
        end
        settle_and_check();
        sweep_boards();

        if (exp_q.size() != 0) begin
            flow_errs++;
            $display("%0d expected peer messages never arrived", exp_q.size());
        end
        $display("Closing report: %0d value errors, %0d stream errors", value_errs, flow_errs);
        if (value_errs == 0 && flow_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
common/fleet_pkg.sv
verilog/stream_fifo.sv
verilog/move_decoder.sv
game_board/game_board.sv
verilog/shot_reporter.sv
verilog/fleet_game_top.sv
verif/fleet_game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module fleet_game_tb -o fleet_game_sim \
    && ./obj_dir/fleet_game_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
exit 0
